// File: dv/tb_drop_pipeline.sv
/* Directed tests on a 100 ns clock with xorshift stimulus from a fixed seed. All DUT
   inputs come from one process, and outputs are sampled on the falling edge */
`timescale 1ns/1ps
`default_nettype none

module tb_drop_pipeline
  import stream_pkg::*;
  import drop_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int MAX_LEN    = 8;

  // Packets per port in each test
  localparam int PT_PKTS  = 3;
  localparam int BP_PKTS  = 4;
  localparam int WD_PKTS  = 3;
  localparam int IND_PKTS = 3;
  localparam int RST_PKTS = 4;

  // The boundary test sends two split 6-beat packets and two whole ones
  localparam int BND_BEATS   = 2 * 6 + 2 * MAX_LEN;
  localparam int TOTAL_BEATS = PORT_COUNT * MAX_LEN * (PT_PKTS + BP_PKTS + IND_PKTS
                               + RST_PKTS + 2) + MAX_LEN * WD_PKTS + BND_BEATS;

  logic                        clk = 1'b0;
  logic                        rst;
  logic [PORT_COUNT-1:0]       drop;
  logic [PORT_COUNT-1:0]       in_tvalid;
  logic [PORT_COUNT-1:0]       in_tlast;
  logic [TDATA_W-1:0]          in_tdata;
  logic [PORT_COUNT-1:0]       in_tready;
  logic [PORT_COUNT-1:0]       out_tvalid;
  logic [PORT_COUNT-1:0]       out_tlast;
  logic [TDATA_W-1:0]          out_tdata;
  logic [PORT_COUNT-1:0]       out_tready;
  logic [DROP_CNT_TOTAL_W-1:0] drop_count;

  // Levels that the next rising edge puts on the DUT inputs
  logic                  rst_lvl;
  logic [PORT_COUNT-1:0] drop_lvl;
  logic [PORT_COUNT-1:0] rdy_lvl;
  // Random out_tready on every port while set
  logic                  bp_on;
  // Ports that must show in_tready high and out_tvalid low each cycle
  logic [PORT_COUNT-1:0] rdy_watch;
  logic                  lat_chk;

  // Beats {pass, tlast, tdata} still to be offered on each port
  logic [DATA_W+1:0]     stim_q [PORT_COUNT][$];
  // Reference model of the passed beats {tlast, tdata} and the cycle each went in
  logic [DATA_W:0]       exp_q [PORT_COUNT][$];
  int                    exp_t_q [PORT_COUNT][$];
  int                    exp_drops [PORT_COUNT];

  // Input transfers seen at the last falling edge, and the pass flag of each held beat
  logic [PORT_COUNT-1:0] acc;
  logic [PORT_COUNT-1:0] cur_pass;
  int                    cycle;
  logic [31:0]           rng = 32'hdb2d_d1d7;
  string                 test_name;

  drop_pipeline_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .drop       (drop),
    .in_tvalid  (in_tvalid),
    .in_tlast   (in_tlast),
    .in_tdata   (in_tdata),
    .in_tready  (in_tready),
    .out_tvalid (out_tvalid),
    .out_tlast  (out_tlast),
    .out_tdata  (out_tdata),
    .out_tready (out_tready),
    .drop_count (drop_count)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  task automatic abort(string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check(string what, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      abort($sformatf("mismatch %s %s: expected 0x%0h, actual 0x%0h",
                      test_name, what, expected, actual));
    end
  endtask

  // One clock cycle. Inputs change on the rising edge, and both sides of the
  // DUT are sampled on the falling edge, where every value is settled
  task automatic step();
    logic [31:0]       r;
    logic [DATA_W+1:0] beat;
    logic [DATA_W:0]   want;
    int                t;
    @(posedge clk);
    rst  <= rst_lvl;
    drop <= drop_lvl;
    for (int p = 0; p < PORT_COUNT; p++) begin
      r = next_rand();
      out_tready[p] <= bp_on ? r[0] : rdy_lvl[p];
      if (rst_lvl) begin
        in_tvalid[p] <= 1'b0;
      end else if (!in_tvalid[p] || acc[p]) begin
        // The held beat moved on this edge, so the next one may be offered
        if (stim_q[p].size() != 0) begin
          beat = stim_q[p].pop_front();
          in_tvalid[p]                 <= 1'b1;
          in_tlast[p]                  <= beat[DATA_W];
          in_tdata[p*DATA_W +: DATA_W] <= beat[DATA_W-1:0];
          cur_pass[p] = beat[DATA_W+1];
        end else begin
          in_tvalid[p] <= 1'b0;
        end
      end
    end
    @(negedge clk);
    cycle++;
    acc = '0;
    if (!rst) begin
      for (int p = 0; p < PORT_COUNT; p++) begin
        acc[p] = in_tvalid[p] & in_tready[p];
        // A beat of a packet that the boundary rule passes is owed at the output
        if (acc[p] && cur_pass[p]) begin
          exp_q[p].push_back({in_tlast[p], in_tdata[p*DATA_W +: DATA_W]});
          exp_t_q[p].push_back(cycle);
        end
        if (rdy_watch[p]) begin
          check($sformatf("port %0d in_tready", p), 64'd1, 64'(in_tready[p]));
          check($sformatf("port %0d out_tvalid", p), 64'd0, 64'(out_tvalid[p]));
        end
        if (out_tvalid[p] && out_tready[p]) begin
          if (exp_q[p].size() == 0) begin
            abort($sformatf("Port %0d delivered a beat that should not exist", p));
          end else begin
            want = exp_q[p].pop_front();
            t    = exp_t_q[p].pop_front();
            check($sformatf("port %0d beat", p), 64'(want),
                  64'({out_tlast[p], out_tdata[p*DATA_W +: DATA_W]}));
            if (lat_chk) begin
              check($sformatf("port %0d latency", p), 64'd2, 64'(cycle - t));
            end
          end
        end
      end
    end
  endtask

  // Anything still to send, held at the input or owed at the output
  function automatic logic busy();
    logic b;
    b = |(in_tvalid & ~acc);
    for (int p = 0; p < PORT_COUNT; p++) begin
      if (stim_q[p].size() != 0 || exp_q[p].size() != 0) begin
        b = 1'b1;
      end
    end
    return b;
  endfunction

  // A few spare cycles catch stray beats and late counter updates
  task automatic drain();
    while (busy()) begin
      step();
    end
    repeat (4) step();
  endtask

  task automatic queue_beats(int p, int n, logic last, logic pass);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = next_rand();
      stim_q[p].push_back({pass, last && (i == n - 1), r[DATA_W-1:0]});
    end
  endtask

  task automatic queue_packets(int p, int count, logic pass);
    int len;
    for (int k = 0; k < count; k++) begin
      len = 1 + int'(next_rand() % MAX_LEN);
      queue_beats(p, len, 1'b1, pass);
      if (!pass) begin
        exp_drops[p]++;
      end
    end
  endtask

  task automatic check_counters();
    logic [DROP_CNT_TOTAL_W-1:0] want;
    for (int p = 0; p < PORT_COUNT; p++) begin
      want[p*DROP_CNT_W +: DROP_CNT_W] = DROP_CNT_W'(exp_drops[p]);
    end
    check("drop_count", 64'(want), 64'(drop_count));
  endtask

  // Beats still in flight are lost in a reset, so the model starts over
  task automatic apply_reset(int cycles);
    rst_lvl = 1'b1;
    for (int p = 0; p < PORT_COUNT; p++) begin
      stim_q[p].delete();
    end
    repeat (cycles) step();
    rst_lvl = 1'b0;
    step();
    for (int p = 0; p < PORT_COUNT; p++) begin
      exp_q[p].delete();
      exp_t_q[p].delete();
      exp_drops[p] = 0;
    end
  endtask

  task automatic test_pass_through();
    test_name = "pass_through";
    lat_chk   = 1'b1;
    for (int p = 0; p < PORT_COUNT; p++) begin
      queue_packets(p, PT_PKTS, 1'b1);
    end
    drain();
    lat_chk = 1'b0;
    check_counters();
  endtask

  task automatic test_back_pressure();
    test_name = "back_pressure";
    bp_on     = 1'b1;
    for (int p = 0; p < PORT_COUNT; p++) begin
      queue_packets(p, BP_PKTS, 1'b1);
    end
    drain();
    bp_on = 1'b0;
    check_counters();
  endtask

  // Port 2 drops with out_tready held low, so its input must still drain
  task automatic test_whole_drop();
    test_name   = "whole_drop";
    drop_lvl[2] = 1'b1;
    rdy_lvl[2]  = 1'b0;
    repeat (3) step();
    rdy_watch[2] = 1'b1;
    queue_packets(2, WD_PKTS, 1'b0);
    drain();
    rdy_watch[2] = 1'b0;
    check_counters();
    drop_lvl[2] = 1'b0;
    rdy_lvl[2]  = 1'b1;
    repeat (3) step();
  endtask

  // Port 1 pauses mid-packet while drop changes
  task automatic test_boundary();
    test_name = "boundary";
    // Drop raised mid-packet lets that packet finish and takes the next one
    queue_beats(1, 3, 1'b0, 1'b1);
    drain();
    drop_lvl[1] = 1'b1;
    repeat (3) step();
    queue_beats(1, 3, 1'b1, 1'b1);
    queue_packets(1, 1, 1'b0);
    drain();
    check_counters();
    // Drop lowered mid-packet still removes the rest of that packet
    queue_beats(1, 3, 1'b0, 1'b0);
    drain();
    drop_lvl[1] = 1'b0;
    repeat (3) step();
    queue_beats(1, 3, 1'b1, 1'b0);
    exp_drops[1]++;
    queue_packets(1, 1, 1'b1);
    drain();
    check_counters();
  endtask

  task automatic test_port_independence();
    test_name   = "port_independence";
    drop_lvl[3] = 1'b1;
    repeat (3) step();
    bp_on = 1'b1;
    for (int p = 0; p < PORT_COUNT; p++) begin
      queue_packets(p, IND_PKTS, p != 3);
    end
    drain();
    bp_on       = 1'b0;
    drop_lvl[3] = 1'b0;
    repeat (3) step();
    check_counters();
  endtask

  // A stalled output lets both slices fill up, so the reset has full entries to clear
  task automatic test_reset();
    test_name = "reset";
    rdy_lvl   = '0;
    for (int p = 0; p < PORT_COUNT; p++) begin
      queue_packets(p, RST_PKTS, 1'b1);
    end
    repeat (10) step();
    apply_reset(5);
    check("out_tvalid", 64'd0, 64'(out_tvalid));
    check("in_tready", 64'((1 << PORT_COUNT) - 1), 64'(in_tready));
    check_counters();
    rdy_lvl = '1;
    // Traffic flows again with the usual latency
    lat_chk = 1'b1;
    for (int p = 0; p < PORT_COUNT; p++) begin
      queue_packets(p, 2, 1'b1);
    end
    drain();
    lat_chk = 1'b0;
    check_counters();
  endtask

  initial begin
    rst        <= 1'b1;
    drop       <= '0;
    in_tvalid  <= '0;
    in_tlast   <= '0;
    in_tdata   <= '0;
    out_tready <= '1;
    rst_lvl   = 1'b1;
    drop_lvl  = '0;
    rdy_lvl   = '1;
    bp_on     = 1'b0;
    lat_chk   = 1'b0;
    rdy_watch = '0;
    acc       = '0;
    cur_pass  = '0;
    cycle     = 0;
    test_name = "startup";
    apply_reset(5);
    test_pass_through();
    test_back_pressure();
    test_whole_drop();
    test_boundary();
    test_port_independence();
    test_reset();
    if (busy()) begin
      abort("Model queues still hold beats at the end of the run");
    end else begin
      $display("No errors");
      $finish;
    end
  end

  // Every beat of every test gets 20 cycles
  initial begin
    #(TOTAL_BEATS * 20 * CLK_PERIOD);
    abort("Timeout, the tests did not finish in the allowed time");
  end

endmodule : tb_drop_pipeline

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the drop pipeline testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -f sim.f \
  --top-module tb_drop_pipeline -o tb_drop_pipeline \
  && ./obj_dir/tb_drop_pipeline \
  || exit 1

// File: sim.f
src/stream_pkg.sv
src/drop_pkg.sv
src/axis_bus.sv
src/axis_skid_buffer.sv
src/axis_dropper.sv
src/drop_pipeline_top.sv
dv/tb_drop_pipeline.sv

// File: src/axis_bus.sv
/* All ports travel in one bundle. A beat moves on a port when its tvalid and
   tready are both high, and the source holds its beat until then */
`timescale 1ns/1ps
`default_nettype none

interface axis_bus
  import stream_pkg::*;
();

  // One bit per port
  logic [PORT_COUNT-1:0] tvalid;
  logic [PORT_COUNT-1:0] tlast;

  // Flat data lanes, port i at [i*DATA_W +: DATA_W]
  logic [TDATA_W-1:0]    tdata;

  // Back-pressure from the sink, one bit per port
  logic [PORT_COUNT-1:0] tready;

  // Side that produces beats
  modport src (
    output tvalid,
    output tlast,
    output tdata,
    input  tready
  );

  // Side that consumes beats, the mirror of src
  modport snk (
    input  tvalid,
    input  tlast,
    input  tdata,
    output tready
  );

endinterface : axis_bus

`default_nettype wire

// File: src/axis_dropper.sv
/* Drops whole packets only and decides at packet boundaries. The drop input costs
   one cycle of delay, and the per-port counters wrap */
`timescale 1ns/1ps
`default_nettype none

module axis_dropper
  import stream_pkg::*;
  import drop_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic [PORT_COUNT-1:0]       drop,
  output logic [DROP_CNT_TOTAL_W-1:0] drop_count,
  axis_bus.snk                        up,
  axis_bus.src                        dn
);

  // Drop level after its input register
  logic [PORT_COUNT-1:0] drop_r;

  // High while a port is idle or has just moved a tlast beat
  logic [PORT_COUNT-1:0] sop;

  // Decision taken at the start of the packet in flight.
  // It is only looked at while sop is low
  logic [PORT_COUNT-1:0] dropping;

  // Drop decision for the beat offered this cycle
  logic [PORT_COUNT-1:0] to_drop;

  // Beat transfers on the upstream side
  logic [PORT_COUNT-1:0] up_xfer;

  // Dropped-packet counters, one per port
  logic [DROP_CNT_W-1:0] cnt [PORT_COUNT];

  // The drop level is registered once and takes effect from drop_r
  always_ff @(posedge clk) begin
    if (rst) begin
      drop_r <= {PORT_COUNT{DROP_R_RST}};
    end else begin
      drop_r <= drop;
    end
  end

  // Same-cycle rule.
  // At a packet start the current drop level decides at once, and
  // inside a packet the decision stored at its start holds until tlast
  always_comb begin
    for (int i = 0; i < PORT_COUNT; i++) begin
      to_drop[i] = sop[i] ? drop_r[i] : dropping[i];
    end
  end

  // While dropping, tready is forced high, so a dropped packet drains at full
  // rate whatever dn does
  assign up.tready = dn.tready | to_drop;
  assign up_xfer   = up.tvalid & up.tready;

  // Dropped beats never reach dn.
  // tlast and tdata pass through, and tvalid alone qualifies them
  assign dn.tvalid = up.tvalid & ~to_drop;
  assign dn.tlast  = up.tlast;
  assign dn.tdata  = up.tdata;

  // Packet boundary tracking
  always_ff @(posedge clk) begin
    if (rst) begin
      sop      <= {PORT_COUNT{SOP_RST}};
      dropping <= {PORT_COUNT{DROPPING_RST}};
    end else begin
      for (int i = 0; i < PORT_COUNT; i++) begin
        if (up_xfer[i]) begin
          // The beat after a tlast opens a new packet
          sop[i]      <= up.tlast[i];
          // Keep the decision for the rest of the packet.
          // A tlast clears it, so the next start decides afresh
          dropping[i] <= to_drop[i] & ~up.tlast[i];
        end
      end
    end
  end

  // A counter steps once per dropped packet, on its tlast transfer.
  // The new value shows in the following cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < PORT_COUNT; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < PORT_COUNT; i++) begin
        if (up_xfer[i] && up.tlast[i] && to_drop[i]) begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  // Flatten the counters onto the output vector, port 0 lowest
  always_comb begin
    for (int i = 0; i < PORT_COUNT; i++) begin
      drop_count[i*DROP_CNT_W +: DROP_CNT_W] = cnt[i];
    end
  end

endmodule : axis_dropper

`default_nettype wire

// File: src/axis_skid_buffer.sv
/* One beat per cycle per port with one cycle of latency. Upstream tready is a
   register output and falls only when both entries of a port are full */
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer
  import stream_pkg::*;
(
  input  logic clk,
  input  logic rst,
  axis_bus.snk up,
  axis_bus.src dn
);

  // Output entry of each port, which drives dn directly
  logic [PORT_COUNT-1:0] out_valid;
  logic [PORT_COUNT-1:0] out_last;
  logic [TDATA_W-1:0]    out_data;

  // Skid entry of each port.
  // It catches the beat that was accepted while dn stalled
  logic [PORT_COUNT-1:0] skid_valid;
  logic [PORT_COUNT-1:0] skid_last;
  logic [TDATA_W-1:0]    skid_data;

  // Load enables for the two entries
  logic [PORT_COUNT-1:0] out_load;
  logic [PORT_COUNT-1:0] skid_load;

  always_comb begin
    // The output entry may take a new beat when it is empty or is being read
    out_load  = dn.tready | ~out_valid;
    // A beat accepted while the output entry is stuck must go to the skid entry.
    // It is only accepted when the skid entry is empty
    skid_load = ~out_load & up.tvalid & ~skid_valid;
  end

  // Occupancy of the two entries
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid  <= '0;
      skid_valid <= '0;
    end else begin
      for (int i = 0; i < PORT_COUNT; i++) begin
        if (out_load[i]) begin
          // A waiting skid beat goes first and blocks up for this cycle.
          // Otherwise the incoming beat, if any, is taken straight in
          out_valid[i]  <= skid_valid[i] | up.tvalid[i];
          skid_valid[i] <= 1'b0;
        end else if (skid_load[i]) begin
          skid_valid[i] <= 1'b1;
        end
      end
    end
  end

  // Payload of the two entries, qualified by the valid bits above
  always_ff @(posedge clk) begin
    for (int i = 0; i < PORT_COUNT; i++) begin
      if (out_load[i]) begin
        if (skid_valid[i]) begin
          out_data[i*DATA_W +: DATA_W] <= skid_data[i*DATA_W +: DATA_W];
          out_last[i]                  <= skid_last[i];
        end else begin
          out_data[i*DATA_W +: DATA_W] <= up.tdata[i*DATA_W +: DATA_W];
          out_last[i]                  <= up.tlast[i];
        end
      end
      if (skid_load[i]) begin
        skid_data[i*DATA_W +: DATA_W] <= up.tdata[i*DATA_W +: DATA_W];
        skid_last[i]                  <= up.tlast[i];
      end
    end
  end

  // Ready depends only on the skid register.
  // There is no combinational path from dn.tready back to up.tready
  assign up.tready = ~skid_valid;

  // Downstream sees the output entry
  assign dn.tvalid = out_valid;
  assign dn.tlast  = out_last;
  assign dn.tdata  = out_data;

endmodule : axis_skid_buffer

`default_nettype wire

// File: src/drop_pipeline_top.sv
/* Plain per-port vectors outside, with lane i of tdata at [i*DATA_W +: DATA_W].
   A passed beat leaves two cycles after it enters when there is no back-pressure */
`timescale 1ns/1ps
`default_nettype none

module drop_pipeline_top
  import stream_pkg::*;
  import drop_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,

  // Drop level per port, sampled at packet boundaries
  input  logic [PORT_COUNT-1:0]       drop,

  // Ingress streams
  input  logic [PORT_COUNT-1:0]       in_tvalid,
  input  logic [PORT_COUNT-1:0]       in_tlast,
  input  logic [TDATA_W-1:0]          in_tdata,
  output logic [PORT_COUNT-1:0]       in_tready,

  // Egress streams
  output logic [PORT_COUNT-1:0]       out_tvalid,
  output logic [PORT_COUNT-1:0]       out_tlast,
  output logic [TDATA_W-1:0]          out_tdata,
  input  logic [PORT_COUNT-1:0]       out_tready,

  // Dropped-packet counters, port i at [i*DROP_CNT_W +: DROP_CNT_W]
  output logic [DROP_CNT_TOTAL_W-1:0] drop_count
);

  // Boundary buses and the two internal stage links
  axis_bus bus_in ();
  axis_bus bus_a ();
  axis_bus bus_b ();
  axis_bus bus_out ();

  // Ingress pins onto bus_in
  assign bus_in.tvalid = in_tvalid;
  assign bus_in.tlast  = in_tlast;
  assign bus_in.tdata  = in_tdata;
  assign in_tready     = bus_in.tready;

  // Ingress slice keeps the external ready off the dropper's paths
  axis_skid_buffer ingress_i (
    .clk (clk),
    .rst (rst),
    .up  (bus_in.snk),
    .dn  (bus_a.src)
  );

  // Packet dropper between the two slices
  axis_dropper dropper_i (
    .clk        (clk),
    .rst        (rst),
    .drop       (drop),
    .drop_count (drop_count),
    .up         (bus_a.snk),
    .dn         (bus_b.src)
  );

  // Egress slice registers the dropper's combinational outputs
  axis_skid_buffer egress_i (
    .clk (clk),
    .rst (rst),
    .up  (bus_b.snk),
    .dn  (bus_out.src)
  );

  // bus_out onto the egress pins
  assign out_tvalid     = bus_out.tvalid;
  assign out_tlast      = bus_out.tlast;
  assign out_tdata      = bus_out.tdata;
  assign bus_out.tready = out_tready;

endmodule : drop_pipeline_top

`default_nettype wire

// File: src/drop_pkg.sv
/* Counters are 16 bits per port and wrap without saturation */
`default_nettype none

package drop_pkg;

  import stream_pkg::*;

  // Width of one dropped-packet counter
  localparam int DROP_CNT_W = 16;

  // Flat counter vector, port i at bits [i*DROP_CNT_W +: DROP_CNT_W]
  localparam int DROP_CNT_TOTAL_W = PORT_COUNT * DROP_CNT_W;

  // Reset values of the per-port drop state.
  // A port leaves reset idle, which counts as a packet start
  localparam logic SOP_RST      = 1'b1;
  localparam logic DROPPING_RST = 1'b0;
  localparam logic DROP_R_RST   = 1'b0;

endpackage : drop_pkg

`default_nettype wire

// File: src/stream_pkg.sv
/* Built for a single configuration of four byte-wide ports. Every bus, slice and
   counter vector is sized from these constants */
`default_nettype none

package stream_pkg;

  // Number of independent stream ports that are carried side by side.
  // Ports share the clock and reset only, and their handshakes never interact
  localparam int PORT_COUNT = 4;

  // Width of one tdata lane in bits
  localparam int DATA_W = 8;

  // Width of the flat tdata vector that holds all lanes.
  // Lane i sits at bits [i*DATA_W +: DATA_W], so port 0 is the least significant
  localparam int TDATA_W = PORT_COUNT * DATA_W;

  // There is no tkeep or tuser sideband.
  // A beat is exactly one tdata lane plus its tlast bit

endpackage : stream_pkg

`default_nettype wire
